/* build.f */
+incdir+.
corrdet_pkg.sv
meas_promote.sv
window_timer.sv
isect_counters.sv
scan_ctrl.sv
result_fifo.sv
corrdet.sv
tb_corrdet.sv

/* corrdet.sv */
`include "corrdet_defines.svh"

module corrdet (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  // Sample strobe, one sample per high cycle
  input  logic                                i_cg,
  input  logic [31:0]                         i_window_length,

  // Measurements
  input  logic [`CD_N_EVENTS-1:0]             i_events,
  input  logic [`CD_N_BSTATES-1:0]            i_bstates,
  input  logic [`CD_N_NORMALS*`CD_DATA_W-1:0] i_normals,

  // Per-pair result filter, applied on the output side
  input  logic [`CD_N_RESULTS-1:0]            i_enables,
  input  logic [`CD_N_RESULTS*`CD_DATA_W-1:0] i_thresholds,

  // Result stream
  input  logic                                i_result_ready,
  output logic                                o_result_valid,
  output logic [`CD_IDX_W-1:0]                o_result_idx,
  output logic [`CD_DATA_W-1:0]               o_result_data,
  // Flips once per window
  output logic                                o_result_arq
);

  corrdet_pkg::meas_flags_t flags;
  logic                     boundary;
  logic                     snap;
  logic [`CD_IDX_W-1:0]     scan_idx;
  logic [`CD_DATA_W-1:0]    snap_count;
  logic                     push;
  corrdet_pkg::result_t     push_data;
  logic                     fifo_full;
  corrdet_pkg::result_t     fifo_data;
  // Window marker
  logic                     arq_q;

  // Inputs to per-sample flags
  meas_promote u_promote (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_cg      (i_cg),
    .i_events  (i_events),
    .i_bstates (i_bstates),
    .i_normals (i_normals),
    .o_flags   (flags)
  );

  // Rectangular window
  window_timer u_timer (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_cg            (i_cg),
    .i_window_length (i_window_length),
    .o_boundary      (boundary)
  );

  // AND counts per pair, plus the frozen bank
  isect_counters u_isect (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_cg         (i_cg),
    .i_flags      (flags),
    .i_boundary   (boundary),
    .i_snap       (snap),
    .i_scan_idx   (scan_idx),
    .o_snap_count (snap_count)
  );

  // Walks the bank after each boundary
  scan_ctrl u_scan (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_boundary   (boundary),
    .i_snap_count (snap_count),
    .i_enables    (i_enables),
    .i_thresholds (i_thresholds),
    .i_full       (fifo_full),
    .o_snap       (snap),
    .o_scan_idx   (scan_idx),
    .o_push       (push),
    .o_push_data  (push_data)
  );

  result_fifo u_fifo (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_push      (push),
    .i_push_data (push_data),
    .i_ready     (i_result_ready),
    .o_full      (fifo_full),
    .o_valid     (o_result_valid),
    .o_data      (fifo_data)
  );

  // Marker flips the cycle after a boundary
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      arq_q <= 1'b0;
    end else if (boundary) begin
      arq_q <= ~arq_q;
    end
  end

  assign o_result_arq  = arq_q;
  assign o_result_idx  = fifo_data.idx;
  assign o_result_data = fifo_data.data;

endmodule

/* corrdet_defines.svh */
`ifndef CORRDET_DEFINES_SVH
`define CORRDET_DEFINES_SVH

// Measurement input counts
`define CD_N_EVENTS   2
`define CD_N_BSTATES  2
`define CD_N_NORMALS  2

// Byte width shared by normals, thresholds and pair counts
`define CD_DATA_W     8

// Each bstate implies level, rise and fall flags
`define CD_N_MEAS     (`CD_N_EVENTS + 3 * `CD_N_BSTATES + `CD_N_NORMALS)

// Unordered pairs, (m*m - m) / 2
`define CD_N_RESULTS  ((`CD_N_MEAS * (`CD_N_MEAS - 1)) / 2)

// Pair index width
`define CD_IDX_W      $clog2(`CD_N_RESULTS)

// Result queue entries, power of two
`define CD_FIFO_DEPTH 16

`endif

/* corrdet_pkg.sv */
`include "corrdet_defines.svh"

package corrdet_pkg;

  // One flag per measurement for the current sample
  // Low to high: events, bstate levels, rises, falls, normals
  typedef logic [`CD_N_MEAS-1:0] meas_flags_t;

  // Queued detection result
  typedef struct packed {
    // Row-major pair number
    logic [`CD_IDX_W-1:0]  idx;
    // Intersection count at the window end
    logic [`CD_DATA_W-1:0] data;
  } result_t;

  // Pair scanner states
  typedef enum logic [1:0] {
    // Waiting for a window boundary
    SC_IDLE,
    // Testing one pair per cycle
    SC_SCAN,
    // Holding a passing pair until the FIFO has room
    SC_PUSH
  } scan_state_e;

endpackage

/* isect_counters.sv */
`include "corrdet_defines.svh"

module isect_counters (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_cg,
  input  corrdet_pkg::meas_flags_t i_flags,
  input  logic                     i_boundary,
  input  logic                     i_snap,
  input  logic [`CD_IDX_W-1:0]     i_scan_idx,
  output logic [`CD_DATA_W-1:0]    o_snap_count
);

  // Saturation value of a count
  localparam logic [`CD_DATA_W-1:0] CNT_MAX = {`CD_DATA_W{1'b1}};

  // Snapshot bank as seen by the read mux
  logic [`CD_DATA_W-1:0] snap_rd [`CD_N_RESULTS];

  // Row a, column b, with a < b
  for (genvar a = 0; a < `CD_N_MEAS - 1; a++) begin : g_row
    for (genvar b = a + 1; b < `CD_N_MEAS; b++) begin : g_col
      // Row-major pair number
      localparam int K = a * `CD_N_MEAS - (a * (a + 1)) / 2 + (b - a - 1);

      // Live count for the window in progress
      logic [`CD_DATA_W-1:0] live_q;
      // Final count of the last scanned window
      logic [`CD_DATA_W-1:0] snap_q;
      // Both measurements set this sample
      logic                  hit;
      // Count including the current sample
      logic [`CD_DATA_W-1:0] live_nxt;

      assign hit = i_flags[a] && i_flags[b];

      // Stick at the top instead of wrapping
      assign live_nxt = (hit && (live_q != CNT_MAX)) ? live_q + 1'b1 : live_q;

      always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          live_q <= '0;
        end else if (i_cg) begin
          // Boundary sample lands in the snapshot, live restarts
          if (i_boundary) begin
            live_q <= '0;
          end else begin
            live_q <= live_nxt;
          end
        end
      end

      // Scanner asks for a snapshot together with the boundary
      always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          snap_q <= '0;
        end else if (i_snap) begin
          snap_q <= live_nxt;
        end
      end

      assign snap_rd[K] = snap_q;
    end
  end

  // Read port for the scanner, zero past the last pair
  assign o_snap_count = (i_scan_idx < `CD_N_RESULTS) ? snap_rd[i_scan_idx] : '0;

  // Snapshot only ever loads on a strobed boundary
  a_snap_on_boundary : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_snap |-> (i_boundary && i_cg)
  ) else $error("isect_counters: snapshot outside a window boundary");

endmodule

/* meas_promote.sv */
`include "corrdet_defines.svh"

module meas_promote (
  input  logic                                i_clk,
  input  logic                                i_arst_n,
  input  logic                                i_cg,
  input  logic [`CD_N_EVENTS-1:0]             i_events,
  input  logic [`CD_N_BSTATES-1:0]            i_bstates,
  input  logic [`CD_N_NORMALS*`CD_DATA_W-1:0] i_normals,
  output corrdet_pkg::meas_flags_t            o_flags
);

  // Bstates as seen on the previous strobed sample
  logic [`CD_N_BSTATES-1:0] bstates_q;
  // Edge flags derived from current vs previous
  logic [`CD_N_BSTATES-1:0] rise;
  logic [`CD_N_BSTATES-1:0] fall;
  // Top bit of each normal byte
  logic [`CD_N_NORMALS-1:0] normal_msb;

  // Only strobed samples advance the history
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bstates_q <= '0;
    end else if (i_cg) begin
      bstates_q <= i_bstates;
    end
  end

  // Low then high is a rise, high then low is a fall
  assign rise = i_bstates & ~bstates_q;
  assign fall = ~i_bstates & bstates_q;

  // Byte sign bit acts as the normal's flag
  always_comb begin
    for (int n = 0; n < `CD_N_NORMALS; n++) begin
      normal_msb[n] = i_normals[n*`CD_DATA_W + `CD_DATA_W - 1];
    end
  end

  // Normals end up in the top bits, events in the bottom
  assign o_flags = {normal_msb, fall, rise, i_bstates, i_events};

endmodule

/* result_fifo.sv */
`include "corrdet_defines.svh"

module result_fifo (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_push,
  input  corrdet_pkg::result_t i_push_data,
  input  logic                 i_ready,
  output logic                 o_full,
  output logic                 o_valid,
  output corrdet_pkg::result_t o_data
);

  localparam int PTR_W = $clog2(`CD_FIFO_DEPTH);

  // Result entries
  corrdet_pkg::result_t mem [`CD_FIFO_DEPTH];
  // Pointers wrap naturally at a power-of-two depth
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  // Entry count needs one extra bit to reach full depth
  logic [PTR_W:0]       fill_q;
  // Consumer takes the head entry
  logic                 pop;

  assign o_full  = (fill_q == (PTR_W + 1)'(`CD_FIFO_DEPTH));
  assign o_valid = (fill_q != '0);
  assign o_data  = mem[rd_ptr_q];
  assign pop     = o_valid && i_ready;

  // Write side
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr_q] <= i_push_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the fill alone
      case ({i_push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Producer must respect the full flag
  a_no_overflow : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_push |-> !o_full
  ) else $error("result_fifo: push into full FIFO");

  // An empty queue stays empty without a push
  a_no_underflow : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (fill_q == '0) && !i_push |=> (fill_q == '0)
  ) else $error("result_fifo: fill count wrapped below zero");

  // Head entry stays put while the consumer stalls
  a_hold_stalled : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data)
  ) else $error("result_fifo: head changed under back-pressure");

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_corrdet \
  -f build.f > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_corrdet > sim.log 2>&1 \
  || echo "Simulator exited with an error" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"

/* scan_ctrl.sv */
`include "corrdet_defines.svh"

module scan_ctrl (
  input  logic                                 i_clk,
  input  logic                                 i_arst_n,
  input  logic                                 i_boundary,
  input  logic [`CD_DATA_W-1:0]                i_snap_count,
  input  logic [`CD_N_RESULTS-1:0]             i_enables,
  input  logic [`CD_N_RESULTS*`CD_DATA_W-1:0]  i_thresholds,
  input  logic                                 i_full,
  output logic                                 o_snap,
  output logic [`CD_IDX_W-1:0]                 o_scan_idx,
  output logic                                 o_push,
  output corrdet_pkg::result_t                 o_push_data
);

  // Last pair number
  localparam logic [`CD_IDX_W-1:0] LAST_IDX = `CD_IDX_W'(`CD_N_RESULTS - 1);

  corrdet_pkg::scan_state_e state_q;
  // Pair under test
  logic [`CD_IDX_W-1:0]     idx_q;
  // Threshold of the current pair
  logic [`CD_DATA_W-1:0]    threshold;
  // Enabled and count reaches threshold
  logic                     pass;
  logic                     at_last;

  assign threshold = i_thresholds[idx_q*`CD_DATA_W +: `CD_DATA_W];
  assign pass      = i_enables[idx_q] && (i_snap_count >= threshold);
  assign at_last   = (idx_q == LAST_IDX);

  // Freeze the window only while idle, a busy scanner drops it
  assign o_snap = i_boundary && (state_q == corrdet_pkg::SC_IDLE);

  // Bank is stable during a scan, so the count can go straight out
  assign o_scan_idx       = idx_q;
  assign o_push           = (state_q == corrdet_pkg::SC_PUSH) && !i_full;
  assign o_push_data.idx  = idx_q;
  assign o_push_data.data = i_snap_count;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= corrdet_pkg::SC_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        corrdet_pkg::SC_IDLE: begin
          // Start from pair 0 the cycle after the boundary
          if (i_boundary) begin
            state_q <= corrdet_pkg::SC_SCAN;
            idx_q   <= '0;
          end
        end
        corrdet_pkg::SC_SCAN: begin
          if (pass) begin
            state_q <= corrdet_pkg::SC_PUSH;
          end else if (at_last) begin
            state_q <= corrdet_pkg::SC_IDLE;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        corrdet_pkg::SC_PUSH: begin
          // Back-pressure holds the pair here
          if (!i_full) begin
            if (at_last) begin
              state_q <= corrdet_pkg::SC_IDLE;
            end else begin
              state_q <= corrdet_pkg::SC_SCAN;
              idx_q   <= idx_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= corrdet_pkg::SC_IDLE;
        end
      endcase
    end
  end

  // Scan never walks past the last pair
  a_idx_range : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    idx_q < `CD_N_RESULTS
  ) else $error("scan_ctrl: scan index out of range");

  // FIFO full flag must block every push
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_full |-> !o_push
  ) else $error("scan_ctrl: push while FIFO full");

endmodule

/* tb_corrdet.sv */
`include "corrdet_defines.svh"

module tb_corrdet;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = `CD_IDX_W;
  localparam int CNT_MAX = (1 << `CD_DATA_W) - 1;
  localparam logic [31:0] SEED = 32'h3667b140;
  // Stimulus modes
  localparam int MODE_RANDOM = 0;
  localparam int MODE_EDGES = 1;
  localparam int MODE_SATURATE = 2;
  // Sum of all window lengths below, each window budgeted at 2 cycles per sample
  localparam int WIN_SUM = 80 + 96 + 120 + 88 + 100 + 300 + 80;
  localparam int LIMIT = 2 * (2 * WIN_SUM) + 1000;

  logic                                i_clk;
  logic                                i_arst_n;
  logic                                i_cg;
  logic [31:0]                         i_window_length;
  logic [`CD_N_EVENTS-1:0]             i_events;
  logic [`CD_N_BSTATES-1:0]            i_bstates;
  logic [`CD_N_NORMALS*`CD_DATA_W-1:0] i_normals;
  logic [`CD_N_RESULTS-1:0]            i_enables;
  logic [`CD_N_RESULTS*`CD_DATA_W-1:0] i_thresholds;
  logic                                i_result_ready;
  logic                                o_result_valid;
  logic [`CD_IDX_W-1:0]                o_result_idx;
  logic [`CD_DATA_W-1:0]               o_result_data;
  logic                                o_result_arq;

  // Reference model state
  logic [`CD_DATA_W-1:0]    pair_count [`CD_N_RESULTS];
  logic [`CD_N_BSTATES-1:0] prev_bstates;
  corrdet_pkg::result_t     exp_q [$];
  int                       samples;
  int                       windows;
  logic                     exp_arq;
  logic                     arq_prev;
  int                       arq_toggles;
  // Bookkeeping
  int                       errors;
  int                       cycles;
  string                    test_name;
  logic [31:0]              rng;
  logic [31:0]              ready_rng;
  logic                     rand_ready;
  logic [63:0]              mask;

  corrdet DUT (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_cg            (i_cg),
    .i_window_length (i_window_length),
    .i_events        (i_events),
    .i_bstates       (i_bstates),
    .i_normals       (i_normals),
    .i_enables       (i_enables),
    .i_thresholds    (i_thresholds),
    .i_result_ready  (i_result_ready),
    .o_result_valid  (o_result_valid),
    .o_result_idx    (o_result_idx),
    .o_result_data   (o_result_data),
    .o_result_arq    (o_result_arq)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Flag layout from low bit up: events, levels, rises, falls, normal sign bits
  function automatic logic [`CD_N_MEAS-1:0] expected_flags(
    input logic [`CD_N_EVENTS-1:0]             ev,
    input logic [`CD_N_BSTATES-1:0]            bs,
    input logic [`CD_N_BSTATES-1:0]            prev,
    input logic [`CD_N_NORMALS*`CD_DATA_W-1:0] nm
  );
    logic [`CD_N_MEAS-1:0] f;
    f = '0;
    for (int i = 0; i < `CD_N_EVENTS; i++) begin
      f[i] = ev[i];
    end
    for (int i = 0; i < `CD_N_BSTATES; i++) begin
      f[`CD_N_EVENTS + i] = bs[i];
      f[`CD_N_EVENTS + `CD_N_BSTATES + i] = bs[i] && !prev[i];
      f[`CD_N_EVENTS + 2 * `CD_N_BSTATES + i] = !bs[i] && prev[i];
    end
    for (int i = 0; i < `CD_N_NORMALS; i++) begin
      f[`CD_N_EVENTS + 3 * `CD_N_BSTATES + i] = nm[i * `CD_DATA_W + `CD_DATA_W - 1];
    end
    return f;
  endfunction

  // One strobed sample into the model, results queued at the window end
  task automatic sample_model();
    logic [`CD_N_MEAS-1:0] f;
    int                    k;
    corrdet_pkg::result_t  r;
    f = expected_flags(i_events, i_bstates, prev_bstates, i_normals);
    prev_bstates = i_bstates;
    k = 0;
    // Pairs numbered row-major, a < b
    for (int a = 0; a < `CD_N_MEAS - 1; a++) begin
      for (int b = a + 1; b < `CD_N_MEAS; b++) begin
        if (f[a] && f[b] && pair_count[k] != CNT_MAX) begin
          pair_count[k]++;
        end
        k++;
      end
    end
    samples++;
    if (samples == int'(i_window_length)) begin
      for (int p = 0; p < `CD_N_RESULTS; p++) begin
        if (i_enables[p] && pair_count[p] >= i_thresholds[p*`CD_DATA_W +: `CD_DATA_W]) begin
          r.idx = IDX_W'(p);
          r.data = pair_count[p];
          exp_q.push_back(r);
        end
        pair_count[p] = '0;
      end
      samples = 0;
      windows++;
      exp_arq = !exp_arq;
    end
  endtask

  task automatic check_result();
    corrdet_pkg::result_t exp;
    assert (exp_q.size() != 0) else begin
      errors++;
      $display("%s: result idx %0d arrived but none was expected", test_name, o_result_idx);
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      assert (o_result_idx == exp.idx) else begin
        errors++;
        $display("[ERROR] %s: idx expected %0d actual %0d", test_name, exp.idx, o_result_idx);
      end
      assert (o_result_data == exp.data) else begin
        errors++;
        $display("[ERROR] %s: data expected %0d actual %0d", test_name, exp.data,
                 o_result_data);
      end
    end
  endtask

  // Midway between edges everything is settled, checks before the model step
  always @(negedge i_clk) begin
    if (i_arst_n) begin
      if (o_result_arq != arq_prev) begin
        arq_toggles++;
      end
      arq_prev = o_result_arq;
      assert (o_result_arq == exp_arq) else begin
        errors++;
        $display("[ERROR] %s: arq expected %0b actual %0b", test_name, exp_arq, o_result_arq);
      end
      // Nothing may come out before the first window closes
      if (windows == 0) begin
        assert (!o_result_valid) else begin
          errors++;
          $display("[ERROR] %s: valid expected 0 actual 1", test_name);
        end
      end
      if (o_result_valid && i_result_ready) begin
        check_result();
      end
      if (i_cg) begin
        sample_model();
      end
    end
  end

  // Stalled head must not move
  a_hold : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_result_valid && !i_result_ready |=>
      o_result_valid && $stable(o_result_idx) && $stable(o_result_data)
  ) else begin
    errors++;
    $display("%s: result changed while ready was low", test_name);
  end

  // Disabled pairs are filtered out
  a_enabled : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_result_valid |-> i_enables[o_result_idx]
  ) else begin
    errors++;
    $display("[ERROR] %s: enable of idx %0d expected 1 actual 0", test_name, o_result_idx);
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles in %s", cycles, test_name);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Separate random stream for the consumer
  always @(posedge i_clk) begin
    if (rand_ready) begin
      #1;
      ready_rng = xorshift(ready_rng);
      i_result_ready = ready_rng[0];
    end
  end

  // Thresholds are (random & msk) | set
  task automatic configure(input logic [`CD_N_RESULTS-1:0] en, input logic [7:0] msk,
                           input logic [7:0] set);
    for (int k = 0; k < `CD_N_RESULTS; k++) begin
      rng = xorshift(rng);
      i_thresholds[k*`CD_DATA_W +: `CD_DATA_W] = (rng[7:0] & msk) | set;
    end
    i_enables = en;
  endtask

  // Drives len strobed samples, then drops the strobe
  task automatic run_window(input int len, input int mode);
    int n;
    n = 0;
    i_window_length = len;
    while (n < len) begin
      @(posedge i_clk);
      #1;
      rng = xorshift(rng);
      case (mode)
        MODE_EDGES: begin
          // Gaps in the strobe must not count
          i_cg = rng[0] | rng[1];
          i_events = '0;
          i_bstates = rng[3:2];
          i_normals = '0;
        end
        MODE_SATURATE: begin
          i_cg = 1'b1;
          i_events = '1;
          i_bstates = '0;
          i_normals = '0;
        end
        default: begin
          i_cg = rng[1:0] != 2'b00;
          i_events = rng[3:2];
          i_bstates = rng[5:4];
          i_normals = rng[21:6];
        end
      endcase
      if (i_cg) begin
        n++;
      end
    end
    @(posedge i_clk);
    #1;
    i_cg = 1'b0;
  endtask

  // Scanner back in idle and every expected result consumed
  task automatic drain();
    @(negedge i_clk);
    while (exp_q.size() != 0 || o_result_valid ||
           DUT.u_scan.state_q != corrdet_pkg::SC_IDLE) begin
      @(negedge i_clk);
    end
  endtask

  initial begin
    i_arst_n = 1'b0;
    i_cg = 1'b0;
    i_window_length = 32'd80;
    i_events = '0;
    i_bstates = '0;
    i_normals = '0;
    i_enables = '0;
    i_thresholds = '0;
    i_result_ready = 1'b1;
    for (int k = 0; k < `CD_N_RESULTS; k++) begin
      pair_count[k] = '0;
    end
    prev_bstates = '0;
    samples = 0;
    windows = 0;
    exp_arq = 1'b0;
    arq_prev = 1'b0;
    arq_toggles = 0;
    errors = 0;
    cycles = 0;
    test_name = "reset";
    rng = SEED;
    ready_rng = xorshift(SEED);
    rand_ready = 1'b0;
    repeat (5) @(posedge i_clk);
    #1;
    i_arst_n = 1'b1;

    test_name = "random";
    rand_ready = 1'b1;
    configure('1, 8'h1f, 8'h00);
    run_window(80, MODE_RANDOM);
    run_window(96, MODE_RANDOM);
    drain();
    configure('1, 8'h1f, 8'h00);
    run_window(120, MODE_RANDOM);
    run_window(88, MODE_RANDOM);
    drain();
    rand_ready = 1'b0;
    i_result_ready = 1'b1;

    // Every pair reported, so all edge counts are compared
    test_name = "bstate_edges";
    configure('1, 8'h00, 8'h00);
    run_window(100, MODE_EDGES);
    drain();

    test_name = "saturation";
    configure('1, 8'h00, 8'hff);
    run_window(300, MODE_SATURATE);
    drain();

    // Roughly three quarters enabled, enough to fill the FIFO
    test_name = "backpressure";
    rng = xorshift(rng);
    mask[31:0] = rng;
    rng = xorshift(rng);
    mask[63:32] = rng;
    rng = xorshift(rng);
    mask[31:0] = mask[31:0] | rng;
    rng = xorshift(rng);
    mask[63:32] = mask[63:32] | rng;
    configure(mask[`CD_N_RESULTS-1:0], 8'h00, 8'h00);
    run_window(80, MODE_RANDOM);
    @(negedge i_clk);
    while (!o_result_valid) begin
      @(negedge i_clk);
    end
    repeat (3) @(posedge i_clk);
    #1;
    i_result_ready = 1'b0;
    repeat (40) @(posedge i_clk);
    #1;
    i_result_ready = 1'b1;
    drain();

    test_name = "arq_count";
    assert (arq_toggles == windows) else begin
      errors++;
      $display("[ERROR] %s: toggles expected %0d actual %0d", test_name, windows, arq_toggles);
    end
    $display("Run finished: %0d errors, %0d windows, %0d cycles", errors, windows, cycles);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* window_timer.sv */
module window_timer (
  input  logic        i_clk,
  input  logic        i_arst_n,
  input  logic        i_cg,
  input  logic [31:0] i_window_length,
  output logic        o_boundary
);

  // Samples taken so far in the current window
  logic [31:0] count_q;
  // Counter sits on the final sample of the window
  logic        last_sample;

  // A length shortened mid-window still ends it
  assign last_sample = (count_q >= (i_window_length - 32'd1));

  // Boundary only on a strobed sample
  assign o_boundary = i_cg && last_sample;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count_q <= '0;
    end else if (i_cg) begin
      // Wrap to zero after the last sample
      if (last_sample) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  // Zero length wraps the last-sample compare and never ends a window
  a_length_nonzero : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_cg |-> (i_window_length != 32'd0)
  ) else $error("window_timer: window length is zero while sampling");

endmodule
